//--- eth_settings.svh
// Frame FIFO settings

`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// Width of one stream beat
`define ETH_DATA_WIDTH 8

// Number of channel FIFOs
`define ETH_NUM_CHANNELS 4

// Channel index width, covers ETH_NUM_CHANNELS
`define ETH_CHAN_WIDTH 2

// Beats per FIFO
// A frame that would fill the whole buffer by itself is dropped
`define ETH_FIFO_DEPTH 16

`endif

//--- eth_stream_pkg.sv
// Stream data types

`include "eth_settings.svh"

package eth_stream_pkg;

    // Channel number carried with every frame
    typedef logic [`ETH_CHAN_WIDTH-1:0] chan_t;

    // One beat of the byte stream
    // user is the bad-frame flag, only meaningful on the last beat
    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic                       last;
        logic                       user;
    } beat_t;

endpackage

//--- eth_ctrl_pkg.sv
// Control types

package eth_ctrl_pkg;

    // Output arbiter states
    typedef enum logic {
        ARB_IDLE,
        ARB_SEND
    } arb_state_e;

    // Outcome of a finished input frame
    typedef enum logic [1:0] {
        VERDICT_NONE,
        VERDICT_GOOD,
        VERDICT_BAD,
        VERDICT_OVERSIZE
    } frame_verdict_e;

endpackage

//--- eth_stream_if.sv
// Byte stream interface

`timescale 1ns/1ns

interface eth_stream_if;

    eth_stream_pkg::beat_t beat;
    logic                  valid;
    logic                  ready;

    // Producer side
    modport source (
        output beat,
        output valid,
        input  ready
    );

    // Consumer side
    modport sink (
        input  beat,
        input  valid,
        output ready
    );

endinterface

//--- eth_frame_demux.sv
// Input frame demultiplexer

`timescale 1ns/1ns

`include "eth_settings.svh"

module eth_frame_demux (
    input  logic                        logic_clk,
    input  logic                        logic_rst,
    input  logic [`ETH_DATA_WIDTH-1:0]  s_data,
    input  logic                        s_last,
    input  logic                        s_user,
    input  eth_stream_pkg::chan_t       s_chan,
    input  logic                        s_valid,
    output logic                        s_ready,
    eth_stream_if.source                fifo_in [`ETH_NUM_CHANNELS-1:0]
);

    logic                          in_frame;
    eth_stream_pkg::chan_t         chan_reg;
    eth_stream_pkg::chan_t         sel;
    eth_stream_pkg::beat_t         beat;
    logic [`ETH_NUM_CHANNELS-1:0]  ready_vec;

    // Channel comes from the port on the first beat, then from the latch
    assign sel = in_frame ? chan_reg : s_chan;

    assign beat.data = s_data;
    assign beat.last = s_last;
    assign beat.user = s_user;

    // Beat goes to every FIFO, valid only to the selected one
    for (genvar i = 0; i < `ETH_NUM_CHANNELS; i++) begin : g_chan
        assign fifo_in[i].beat  = beat;
        assign fifo_in[i].valid = s_valid && (sel == eth_stream_pkg::chan_t'(i));
        assign ready_vec[i]     = fifo_in[i].ready;
    end

    assign s_ready = ready_vec[sel];

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame <= 1'b0;
            chan_reg <= '0;
        end else if (s_valid && s_ready) begin
            // Hold the channel until the last beat is through
            in_frame <= !s_last;
            chan_reg <= sel;
        end
    end

endmodule

//--- eth_frame_fifo.sv
// Store-and-forward frame FIFO

`timescale 1ns/1ns

`include "eth_settings.svh"

module eth_frame_fifo (
    input  logic          logic_clk,
    input  logic          logic_rst,
    eth_stream_if.sink    wr,
    eth_stream_if.source  rd,
    output logic          good_frame,
    output logic          bad_frame,
    output logic          overflow
);

    localparam int DEPTH = `ETH_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // Pointers carry one extra wrap bit
    typedef logic [AW:0] ptr_t;

    localparam ptr_t LEN_LIMIT = ptr_t'(DEPTH - 1);

    eth_stream_pkg::beat_t        mem [DEPTH];
    ptr_t                         wr_ptr;
    ptr_t                         commit_ptr;
    ptr_t                         rd_ptr;
    ptr_t                         frame_len;
    logic                         oversize;
    logic                         run;
    logic                         full;
    logic                         hits_limit;
    logic                         wr_fire;
    logic                         rd_fire;
    logic                         store;
    eth_ctrl_pkg::frame_verdict_e verdict;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Beats owned by the frame in progress
    assign frame_len  = wr_ptr - commit_ptr;
    assign hits_limit = (frame_len == LEN_LIMIT);

    // A frame never grows past DEPTH-1 beats, so a full buffer always
    // holds committed data and must stall the writer
    assign wr.ready = run && (oversize || !full);
    assign wr_fire  = wr.valid && wr.ready;
    assign store    = wr_fire && !oversize && !hits_limit;

    // Read side only sees committed frames
    assign rd.valid = (rd_ptr != commit_ptr);
    assign rd.beat  = mem[rd_ptr[AW-1:0]];
    assign rd_fire  = rd.valid && rd.ready;

    always_ff @(posedge logic_clk) begin
        if (store) begin
            mem[wr_ptr[AW-1:0]] <= wr.beat;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            oversize   <= 1'b0;
            run        <= 1'b0;
            verdict    <= eth_ctrl_pkg::VERDICT_NONE;
        end else begin
            run     <= 1'b1;
            verdict <= eth_ctrl_pkg::VERDICT_NONE;
            if (wr_fire) begin
                if (oversize || hits_limit) begin
                    // Too long, throw away what was stored and the rest
                    wr_ptr <= commit_ptr;
                    if (wr.beat.last) begin
                        oversize <= 1'b0;
                        verdict  <= eth_ctrl_pkg::VERDICT_OVERSIZE;
                    end else begin
                        oversize <= 1'b1;
                    end
                end else if (wr.beat.last && wr.beat.user) begin
                    wr_ptr  <= commit_ptr;
                    verdict <= eth_ctrl_pkg::VERDICT_BAD;
                end else if (wr.beat.last) begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                    verdict    <= eth_ctrl_pkg::VERDICT_GOOD;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // One status pulse per finished frame
    assign good_frame = (verdict == eth_ctrl_pkg::VERDICT_GOOD);
    assign bad_frame  = (verdict == eth_ctrl_pkg::VERDICT_BAD);
    assign overflow   = (verdict == eth_ctrl_pkg::VERDICT_OVERSIZE);

endmodule

//--- eth_frame_arbiter.sv
// Round-robin frame arbiter

`timescale 1ns/1ns

`include "eth_settings.svh"

module eth_frame_arbiter (
    input  logic                        logic_clk,
    input  logic                        logic_rst,
    eth_stream_if.sink                  fifo_out [`ETH_NUM_CHANNELS-1:0],
    output logic [`ETH_DATA_WIDTH-1:0]  m_data,
    output logic                        m_last,
    output eth_stream_pkg::chan_t       m_chan,
    output logic                        m_valid,
    input  logic                        m_ready
);

    localparam int N = `ETH_NUM_CHANNELS;

    eth_ctrl_pkg::arb_state_e      state;
    eth_stream_pkg::chan_t         grant;
    eth_stream_pkg::chan_t         rr_ptr;
    eth_stream_pkg::chan_t         pick;
    logic                          found;
    logic [N-1:0]                  valid_vec;
    eth_stream_pkg::beat_t         beat_vec [N];
    logic                          sending;

    assign sending = (state == eth_ctrl_pkg::ARB_SEND);

    // Gather FIFO outputs, ready only back to the granted one
    for (genvar i = 0; i < N; i++) begin : g_chan
        assign valid_vec[i]       = fifo_out[i].valid;
        assign beat_vec[i]        = fifo_out[i].beat;
        assign fifo_out[i].ready  = sending && m_ready
                                    && (grant == eth_stream_pkg::chan_t'(i));
    end

    // Next channel after the previous grant that has a frame
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(rr_ptr) + k) % N;
            if (!found && valid_vec[idx]) begin
                found = 1'b1;
                pick  = eth_stream_pkg::chan_t'(idx);
            end
        end
    end

    assign m_valid = sending && valid_vec[grant];
    assign m_data  = beat_vec[grant].data;
    assign m_last  = beat_vec[grant].last;
    assign m_chan  = grant;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state  <= eth_ctrl_pkg::ARB_IDLE;
            grant  <= '0;
            // Channel 0 wins first
            rr_ptr <= eth_stream_pkg::chan_t'(N - 1);
        end else begin
            case (state)
                eth_ctrl_pkg::ARB_IDLE: begin
                    if (found) begin
                        grant <= pick;
                        state <= eth_ctrl_pkg::ARB_SEND;
                    end
                end
                eth_ctrl_pkg::ARB_SEND: begin
                    // Grant held for the whole frame
                    if (m_valid && m_ready && m_last) begin
                        rr_ptr <= grant;
                        state  <= eth_ctrl_pkg::ARB_IDLE;
                    end
                end
                default: state <= eth_ctrl_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

//--- eth_frame_fifo_top.sv
// Multi-channel frame FIFO top

`timescale 1ns/1ns

`include "eth_settings.svh"

module eth_frame_fifo_top (
    input  logic                          logic_clk,
    input  logic                          logic_rst,
    // Input stream
    input  logic [`ETH_DATA_WIDTH-1:0]    s_data,
    input  logic                          s_last,
    input  logic                          s_user,
    input  eth_stream_pkg::chan_t         s_chan,
    input  logic                          s_valid,
    output logic                          s_ready,
    // Output stream
    output logic [`ETH_DATA_WIDTH-1:0]    m_data,
    output logic                          m_last,
    output eth_stream_pkg::chan_t         m_chan,
    output logic                          m_valid,
    input  logic                          m_ready,
    // Per-channel status pulses
    output logic [`ETH_NUM_CHANNELS-1:0]  good_frame,
    output logic [`ETH_NUM_CHANNELS-1:0]  bad_frame,
    output logic [`ETH_NUM_CHANNELS-1:0]  overflow
);

    eth_stream_if fifo_in_if  [`ETH_NUM_CHANNELS-1:0] ();
    eth_stream_if fifo_out_if [`ETH_NUM_CHANNELS-1:0] ();

    eth_frame_demux u_demux (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .s_data    (s_data),
        .s_last    (s_last),
        .s_user    (s_user),
        .s_chan    (s_chan),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .fifo_in   (fifo_in_if)
    );

    // One FIFO per channel
    for (genvar i = 0; i < `ETH_NUM_CHANNELS; i++) begin : g_fifo
        eth_frame_fifo u_fifo (
            .logic_clk  (logic_clk),
            .logic_rst  (logic_rst),
            .wr         (fifo_in_if[i]),
            .rd         (fifo_out_if[i]),
            .good_frame (good_frame[i]),
            .bad_frame  (bad_frame[i]),
            .overflow   (overflow[i])
        );
    end

    eth_frame_arbiter u_arbiter (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .fifo_out  (fifo_out_if),
        .m_data    (m_data),
        .m_last    (m_last),
        .m_chan    (m_chan),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

endmodule

//--- tb_eth_frame_assert.sv
// Output stream assertions

`timescale 1ns/1ns

`include "eth_settings.svh"

module tb_eth_frame_assert (
    input logic                          logic_clk,
    input logic                          logic_rst,
    input logic                          s_last,
    input logic                          s_valid,
    input logic                          s_ready,
    input logic [`ETH_DATA_WIDTH-1:0]    m_data,
    input logic                          m_last,
    input eth_stream_pkg::chan_t         m_chan,
    input logic                          m_valid,
    input logic                          m_ready,
    input logic [`ETH_NUM_CHANNELS-1:0]  good_frame,
    input logic [`ETH_NUM_CHANNELS-1:0]  bad_frame,
    input logic [`ETH_NUM_CHANNELS-1:0]  overflow
);

    int fail_count = 0;

    // Stalled beat is held until taken
    a_stall_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (m_valid && !m_ready) |=>
        (m_valid && $stable(m_data) && $stable(m_last) && $stable(m_chan))
    ) else begin
        $error("Output beat changed while stalled");
        fail_count++;
    end

    // Single verdict per channel, right after an input last beat
    for (genvar i = 0; i < `ETH_NUM_CHANNELS; i++) begin : g_chan
        a_one_pulse: assert property (@(posedge logic_clk) disable iff (logic_rst)
            (good_frame[i] || bad_frame[i] || overflow[i]) |->
            ($onehot0({good_frame[i], bad_frame[i], overflow[i]})
             && $past(s_valid && s_ready && s_last))
        ) else begin
            $error("Wrong status pulse on channel %0d", i);
            fail_count++;
        end
    end

endmodule

//--- tb_eth_frame_fifo.sv
// Frame FIFO testbench

`timescale 1ns/1ns

`include "eth_settings.svh"

module tb_eth_frame_fifo;

    localparam int N           = `ETH_NUM_CHANNELS;
    localparam int DEPTH       = `ETH_FIFO_DEPTH;
    localparam int CASE_WORDS  = 512;
    localparam int WAIT_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 20000;

    logic                          logic_clk = 1'b0;
    logic                          logic_rst;
    logic [`ETH_DATA_WIDTH-1:0]    s_data;
    logic                          s_last;
    logic                          s_user;
    eth_stream_pkg::chan_t         s_chan;
    logic                          s_valid;
    logic                          s_ready;
    logic [`ETH_DATA_WIDTH-1:0]    m_data;
    logic                          m_last;
    eth_stream_pkg::chan_t         m_chan;
    logic                          m_valid;
    logic                          m_ready;
    logic [N-1:0]                  good_frame;
    logic [N-1:0]                  bad_frame;
    logic [N-1:0]                  overflow;

    logic [15:0] case_mem [CASE_WORDS];
    // Expected output beats per channel as {last, data}
    logic [8:0]  exp_q [N][$];
    int          exp_good [N];
    int          exp_bad [N];
    int          exp_over [N];
    int          got_good [N];
    int          got_bad [N];
    int          got_over [N];
    int          error_count;
    logic        timed_out;

    eth_frame_fifo_top uut (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .s_data     (s_data),
        .s_last     (s_last),
        .s_user     (s_user),
        .s_chan     (s_chan),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_data     (m_data),
        .m_last     (m_last),
        .m_chan     (m_chan),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .good_frame (good_frame),
        .bad_frame  (bad_frame),
        .overflow   (overflow)
    );

    bind eth_frame_fifo_top tb_eth_frame_assert u_assert (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .s_last     (s_last),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_data     (m_data),
        .m_last     (m_last),
        .m_chan     (m_chan),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .good_frame (good_frame),
        .bad_frame  (bad_frame),
        .overflow   (overflow)
    );

    always #10 logic_clk = ~logic_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // Only good frames shorter than the buffer reach the output
    task automatic build_expected();
        int   pos;
        int   ch;
        int   len;
        logic bad;
        pos = 0;
        while (pos < CASE_WORDS && case_mem[pos] != 16'hffff) begin
            ch  = int'(case_mem[pos][15:12]);
            bad = case_mem[pos][8];
            len = int'(case_mem[pos][7:0]);
            if (len >= DEPTH) begin
                exp_over[ch]++;
            end else if (bad) begin
                exp_bad[ch]++;
            end else begin
                exp_good[ch]++;
                for (int b = 0; b < len; b++) begin
                    exp_q[ch].push_back({b == len - 1, case_mem[pos + 1 + b][7:0]});
                end
            end
            pos += len + 1;
        end
    endtask

    task automatic send_frame(input int pos);
        int   ch;
        int   len;
        int   cycles;
        logic bad;
        logic accepted;
        ch  = int'(case_mem[pos][15:12]);
        bad = case_mem[pos][8];
        len = int'(case_mem[pos][7:0]);
        for (int b = 0; b < len && !timed_out; b++) begin
            s_chan  <= eth_stream_pkg::chan_t'(ch);
            s_data  <= case_mem[pos + 1 + b][7:0];
            s_last  <= (b == len - 1);
            s_user  <= bad && (b == len - 1);
            s_valid <= 1'b1;
            accepted = 1'b0;
            cycles   = 0;
            while (!accepted && cycles < WAIT_LIMIT) begin
                @(posedge logic_clk);
                accepted = s_ready;
                cycles++;
            end
            if (!accepted) begin
                error_count++;
                timed_out = 1'b1;
                $display("Timeout: input on channel %0d stalled for %0d cycles", ch, WAIT_LIMIT);
            end
        end
    endtask

    function automatic logic all_delivered();
        for (int i = 0; i < N; i++) begin
            if (exp_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Random output back-pressure
    always @(posedge logic_clk) begin
        m_ready <= ($urandom % 32'd2) != 0;
    end

    // Scoreboard on every output transfer
    always @(posedge logic_clk) begin
        logic [8:0] want;
        if (!logic_rst && m_valid && m_ready) begin
            if (exp_q[m_chan].size() == 0) begin
                error_count++;
                $display("Unexpected output beat on channel %0d at %0t ns", m_chan, $time);
            end else begin
                want = exp_q[m_chan].pop_front();
                check_value($sformatf("m_data ch%0d", m_chan), m_data, want[7:0]);
                check_value($sformatf("m_last ch%0d", m_chan), m_last, want[8]);
            end
        end
    end

    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            for (int i = 0; i < N; i++) begin
                got_good[i] += int'(good_frame[i]);
                got_bad[i]  += int'(bad_frame[i]);
                got_over[i] += int'(overflow[i]);
            end
        end
    end

    initial begin
        int pos;
        int cycles;
        void'($urandom(82));
        logic_rst   = 1'b1;
        s_data      = '0;
        s_last      = 1'b0;
        s_user      = 1'b0;
        s_chan      = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b0;
        error_count = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < CASE_WORDS; i++) begin
            case_mem[i] = 16'hffff;
        end
        $readmemh("eth_frame_cases.txt", case_mem);
        build_expected();

        repeat (4) @(posedge logic_clk);
        check_value("m_valid", m_valid, 0);
        check_value("s_ready", s_ready, 0);
        check_value("good_frame", good_frame, 0);
        check_value("bad_frame", bad_frame, 0);
        check_value("overflow", overflow, 0);
        logic_rst <= 1'b0;

        // FIFOs open up once out of reset
        cycles = 0;
        while (!s_ready && cycles < WAIT_LIMIT) begin
            @(posedge logic_clk);
            cycles++;
        end
        if (!s_ready) begin
            error_count++;
            timed_out = 1'b1;
            $display("Timeout: s_ready never rose after reset");
        end

        pos = 0;
        while (!timed_out && pos < CASE_WORDS && case_mem[pos] != 16'hffff) begin
            send_frame(pos);
            pos += int'(case_mem[pos][7:0]) + 1;
        end
        s_valid <= 1'b0;
        s_last  <= 1'b0;
        s_user  <= 1'b0;

        cycles = 0;
        while (!timed_out && !all_delivered() && cycles < DRAIN_LIMIT) begin
            @(posedge logic_clk);
            cycles++;
        end
        if (!timed_out && !all_delivered()) begin
            error_count++;
            timed_out = 1'b1;
            $display("Timeout: output frames still missing after %0d cycles", DRAIN_LIMIT);
        end

        // Let the last status pulse be counted
        repeat (2) @(posedge logic_clk);
        check_value("m_valid after drain", m_valid, 0);
        for (int i = 0; i < N; i++) begin
            check_value($sformatf("good_frame[%0d] count", i), got_good[i], exp_good[i]);
            check_value($sformatf("bad_frame[%0d] count", i), got_bad[i], exp_bad[i]);
            check_value($sformatf("overflow[%0d] count", i), got_over[i], exp_over[i]);
        end

        error_count += uut.u_assert.fail_count;
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- eth_frame_cases.txt
// Input frames, one per line: header CBLL then LL data bytes, ffff ends the list
// Header: C channel, B bad flag on the last beat, LL beat count in hex
0004 10 11 12 13
1003 20 21 22
2105 30 31 32 33 34
3001 40
0010 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
0002 60 61
1014 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f 80 81 82 83
100f 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e
2006 a0 a1 a2 a3 a4 a5
3102 b0 b1
0008 c0 c1 c2 c3 c4 c5 c6 c7
200a d0 d1 d2 d3 d4 d5 d6 d7 d8 d9
200c e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb
300c f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb
1008 01 02 03 04 05 06 07 08
3009 09 0a 0b 0c 0d 0e 0f 10 11
0007 12 13 14 15 16 17 18
ffff

//--- tb.f
+incdir+.
eth_stream_pkg.sv
eth_ctrl_pkg.sv
eth_stream_if.sv
eth_frame_demux.sv
eth_frame_fifo.sv
eth_frame_arbiter.sv
eth_frame_fifo_top.sv
tb_eth_frame_assert.sv
tb_eth_frame_fifo.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_eth_frame_fifo -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
